// ==== dv/tb_ibex_shell.sv ====
// Testbench for the core wrapper shell: sleep gate, key refill and scrambled bank.
// Concurrent assertions do the checking; stimulus comes from a seeded LFSR.
// Reads only target addresses that were written before.

`timescale 1ns/1ps
`default_nettype none

module tb_ibex_shell;

  localparam int unsigned NumWords    = 32;
  localparam int unsigned AddrW       = $clog2(NumWords);
  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned NumWrites   = 24;
  localparam int unsigned NumReads    = 32;
  localparam int unsigned KeyDelayMax = 15;
  // Every request may stall one idle cycle, two refills with their delay
  localparam int unsigned TestCycles  = ResetCycles + 20 + 2 * (3 * NumWrites + 5 * NumReads) +
                                        2 * (KeyDelayMax + 8);
  localparam int unsigned WatchdogNs  = (TestCycles + 200) * ClkPeriod;

  logic clk_i, rst_ni, test_en_i;
  logic core_busy_i, debug_req_i, irq_pending_i, irq_nm_i, core_sleep_o;
  logic ram_inval_i, scramble_key_valid_i, scramble_req_o;
  logic [scr_pkg::KeyW-1:0]   scramble_key_i;
  logic [scr_pkg::NonceW-1:0] scramble_nonce_i;
  logic req_valid_i, req_write_i, req_ready_o, rsp_valid_o;
  logic [AddrW-1:0]          req_addr_i;
  logic [mem_pkg::DataW-1:0] req_wdata_i, rsp_rdata_o;
  logic [mem_pkg::IntgW-1:0] req_wintg_i, rsp_rintg_o;

  // Reference model state
  logic [mem_pkg::WordW-1:0]  shadow_word  [NumWords];
  logic [scr_pkg::KeyW-1:0]   shadow_key   [NumWords];
  logic [scr_pkg::NonceW-1:0] shadow_nonce [NumWords];
  logic [scr_pkg::KeyW-1:0]   model_key;
  logic [scr_pkg::NonceW-1:0] model_nonce;
  logic [mem_pkg::WordW-1:0]  exp_word;
  logic [AddrW-1:0]           written_q [$];
  logic busy_d, acc_q, rd_take_q, rd_take, wake, chk_reset;
  logic [31:0] lfsr_q;
  int errors = 0;
  int n_reads;

  ibex_shell_top #(.NumWords(NumWords)) dut0 (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'hD000_0001 : 32'h0);
  endfunction

  // Key low bits XOR nonce low bits XOR address
  function automatic logic [mem_pkg::WordW-1:0] keystream(input logic [scr_pkg::KeyW-1:0] k,
      input logic [scr_pkg::NonceW-1:0] n, input logic [AddrW-1:0] a);
    logic [mem_pkg::WordW-1:0] addr_ext;
    addr_ext = '0;
    addr_ext[AddrW-1:0] = a;
    return k[mem_pkg::WordW-1:0] ^ n[mem_pkg::WordW-1:0] ^ addr_ext;
  endfunction

  task automatic take_bits(input int unsigned n, output logic [63:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  assign rd_take = req_valid_i & req_ready_o & ~req_write_i;
  assign wake    = busy_d | debug_req_i | irq_pending_i | irq_nm_i;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_d      <= 1'b0;
      acc_q       <= 1'b0;
      rd_take_q   <= 1'b0;
      n_reads     <= 0;
      model_key   <= scr_pkg::RstKey;
      model_nonce <= scr_pkg::RstNonce;
    end else begin
      busy_d    <= core_busy_i;
      acc_q     <= req_valid_i & req_ready_o;
      rd_take_q <= rd_take;
      if (req_valid_i && req_ready_o && req_write_i) begin
        shadow_word[req_addr_i]  <= {req_wintg_i, req_wdata_i};
        shadow_key[req_addr_i]   <= model_key;
        shadow_nonce[req_addr_i] <= model_nonce;
      end
      if (rd_take) begin
        n_reads  <= n_reads + 1;
        exp_word <= shadow_word[req_addr_i] ^ keystream(model_key, model_nonce, req_addr_i) ^
                    keystream(shadow_key[req_addr_i], shadow_nonce[req_addr_i], req_addr_i);
      end
      if (scramble_key_valid_i) begin
        model_key   <= scramble_key_i;
        model_nonce <= scramble_nonce_i;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  reset_state_a: assert property (@(posedge clk_i) chk_reset |->
    !scramble_req_o && core_sleep_o && !req_ready_o) else begin
    errors = errors + 1;
    $display("Fail reset state scramble_req_o=%h core_sleep_o=%h req_ready_o=%h",
             $sampled(scramble_req_o), $sampled(core_sleep_o), $sampled(req_ready_o));
  end
  sleep_a: assert property (@(posedge clk_i) disable iff (!rst_ni) core_sleep_o == !wake)
  else begin
    errors = errors + 1;
    $display("Fail core_sleep_o got %h exp %h", $sampled(core_sleep_o), !$sampled(wake));
  end
  ready_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o || scramble_req_o |-> !req_ready_o) else begin
    errors = errors + 1;
    $display("Fail req_ready_o got %h exp 0", $sampled(req_ready_o));
  end
  rsp_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o == rd_take_q) else begin
    errors = errors + 1;
    $display("Response pulse does not follow an accepted read by one cycle");
  end
  rsp_data_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> {rsp_rintg_o, rsp_rdata_o} == exp_word) else begin
    errors = errors + 1;
    $display("Fail rsp_rdata_o got %h exp %h rsp_rintg_o got %h exp %h",
             $sampled(rsp_rdata_o), $sampled(exp_word[mem_pkg::DataW-1:0]),
             $sampled(rsp_rintg_o), $sampled(exp_word[mem_pkg::WordW-1:mem_pkg::DataW]));
  end
  req_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(ram_inval_i) && !$past(scramble_req_o) |-> scramble_req_o) else begin
    errors = errors + 1;
    $display("Key request did not rise after an invalidate");
  end
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(scramble_req_o) |-> scramble_req_o == !$past(scramble_key_valid_i)) else begin
    errors = errors + 1;
    $display("Key request did not stay up until the key arrived, or stayed up after it");
  end
  ready_back_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(scramble_req_o) && !scramble_req_o && !core_sleep_o |-> req_ready_o) else begin
    errors = errors + 1;
    $display("Bank not ready again after the key refill");
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Holds the request from a falling edge until an edge accepts it
  task automatic send_req(input logic wr, input logic [AddrW-1:0] a,
                          input logic [mem_pkg::WordW-1:0] w);
    req_valid_i = 1'b1;
    req_write_i = wr;
    req_addr_i  = a;
    req_wdata_i = w[mem_pkg::DataW-1:0];
    req_wintg_i = w[mem_pkg::WordW-1:mem_pkg::DataW];
    do @(negedge clk_i); while (!acc_q);
    req_valid_i = 1'b0;
  endtask

  task automatic write_random();
    logic [63:0] a;
    logic [63:0] w;
    take_bits(AddrW, a);
    take_bits(mem_pkg::WordW, w);
    send_req(1'b1, a[AddrW-1:0], w[mem_pkg::WordW-1:0]);
    written_q.push_back(a[AddrW-1:0]);
  endtask

  // Random gap, so some reads go back to back
  task automatic read_random();
    logic [63:0] v;
    int idx;
    take_bits(8, v);
    idx = int'(v[7:0]) % written_q.size();
    send_req(1'b0, written_q[idx], '0);
    take_bits(1, v);
    if (v[0]) @(negedge clk_i);
  endtask

  task automatic refill_key();
    logic [63:0] v;
    logic [scr_pkg::KeyW-1:0] k;
    ram_inval_i = 1'b1;
    @(negedge clk_i);
    ram_inval_i = 1'b0;
    take_bits(4, v);
    repeat (v[3:0]) @(negedge clk_i);
    for (int i = 0; i < scr_pkg::KeyW / 64; i++) begin
      take_bits(64, v);
      k[i*64 +: 64] = v;
    end
    take_bits(scr_pkg::NonceW, v);
    scramble_key_i       = k;
    scramble_nonce_i     = v[scr_pkg::NonceW-1:0];
    scramble_key_valid_i = 1'b1;
    @(negedge clk_i);
    scramble_key_valid_i = 1'b0;
    while (!req_ready_o) @(negedge clk_i);
  endtask

  initial begin
    lfsr_q = 32'd41;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    test_en_i = 1'b0;
    {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;
    {ram_inval_i, scramble_key_valid_i, chk_reset} = '0;
    scramble_key_i = '0;
    scramble_nonce_i = '0;
    {req_valid_i, req_write_i, req_addr_i, req_wdata_i, req_wintg_i} = '0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    chk_reset = 1'b1;
    @(negedge clk_i);
    chk_reset = 1'b0;
    // One wake source at a time
    for (int s = 0; s < 4; s++) begin
      core_busy_i   = (s == 0);
      debug_req_i   = (s == 1);
      irq_pending_i = (s == 2);
      irq_nm_i      = (s == 3);
      repeat (2) @(negedge clk_i);
      {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;
      repeat (2) @(negedge clk_i);
    end
    core_busy_i = 1'b1;
    @(negedge clk_i);
    repeat (NumWrites) write_random();
    repeat (NumReads) read_random();
    // Old words first, then fresh writes under the new key
    repeat (2) begin
      refill_key();
      repeat (NumReads) read_random();
      repeat (NumWrites) write_random();
      repeat (NumReads) read_random();
    end
    repeat (4) @(negedge clk_i);
    $display("errors=%0d reads=%0d", errors, n_reads);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, errors=%0d reads=%0d", WatchdogNs, errors, n_reads);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/mem_pkg.sv
rtl/scr_pkg.sv
rtl/sleep_ctrl.sv
rtl/scr_key_regs.sv
rtl/scr_ram.sv
rtl/ibex_shell_top.sv
dv/tb_ibex_shell.sv

// ==== rtl/ibex_shell_top.sv ====
// Core wrapper without the core: clock gate, key store and one scrambled bank.
// Busy, pending interrupt and invalidate come from outside in place of the core.
// NumWords must be a power of two of at least 4.

`timescale 1ns/1ps
`default_nettype none

module ibex_shell_top #(
  parameter  int unsigned NumWords = mem_pkg::DefaultNumWords,
  localparam int unsigned AddrW    = $clog2(NumWords)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      test_en_i,

  input  logic                      core_busy_i,
  input  logic                      debug_req_i,
  input  logic                      irq_pending_i,
  input  logic                      irq_nm_i,
  output logic                      core_sleep_o,

  input  logic                      ram_inval_i,
  input  logic                      scramble_key_valid_i,
  input  logic [scr_pkg::KeyW-1:0]   scramble_key_i,
  input  logic [scr_pkg::NonceW-1:0] scramble_nonce_i,
  output logic                      scramble_req_o,

  input  logic                      req_valid_i,
  input  logic                      req_write_i,
  input  logic [AddrW-1:0]          req_addr_i,
  input  logic [mem_pkg::DataW-1:0] req_wdata_i,
  input  logic [mem_pkg::IntgW-1:0] req_wintg_i,
  output logic                      req_ready_o,

  output logic                      rsp_valid_o,
  output logic [mem_pkg::DataW-1:0] rsp_rdata_o,
  output logic [mem_pkg::IntgW-1:0] rsp_rintg_o
);

  logic                       gated_clk;
  logic                       clk_en;
  logic [scr_pkg::KeyW-1:0]   key_q;
  logic [scr_pkg::NonceW-1:0] nonce_q;
  logic                       key_valid;

  sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .gated_clk_o  (gated_clk),
    .clk_en_o     (clk_en),
    .core_sleep_o (core_sleep_o)
  );

  // Key store runs on the free clock so a refill completes during sleep
  scr_key_regs u_scr_key_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ram_inval_i         (ram_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_q_o             (key_q),
    .nonce_q_o           (nonce_q),
    .key_valid_o         (key_valid)
  );

  scr_ram #(
    .NumWords(NumWords)
  ) u_scr_ram (
    .clk_i      (gated_clk),
    .rst_ni     (rst_ni),
    .clk_en_i   (clk_en),
    .key_valid_i(key_valid),
    .key_i      (key_q),
    .nonce_i    (nonce_q),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_write_i(req_write_i),
    .req_addr_i (req_addr_i),
    .req_wdata_i(req_wdata_i),
    .req_wintg_i(req_wintg_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_rdata_o(rsp_rdata_o),
    .rsp_rintg_o(rsp_rintg_o)
  );

endmodule

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
// Geometry and word layout of the scrambled bank.
// A stored word is the data with its integrity bits on top.
// Integrity is carried through the bank and never checked here.

`default_nettype none

package mem_pkg;

  ////////////////////////////////////////
  // Word layout
  ////////////////////////////////////////

  // Data bits per word
  parameter int unsigned DataW = 32;

  // Integrity bits stored beside the data
  parameter int unsigned IntgW = 7;

  // Full stored word, integrity in the upper bits
  parameter int unsigned WordW = DataW + IntgW;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  // Default depth, must be a power of two of at least 4
  parameter int unsigned DefaultNumWords = 64;

endpackage

`default_nettype wire

// ==== rtl/scr_key_regs.sv ====
// Scrambling key store beside the memory bank.
// A request is held until the provider returns a key; no ready is given back.
// A key presented without a pending request is loaded but does not set key-valid.

`timescale 1ns/1ps
`default_nettype none

module scr_key_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ram_inval_i,
  input  logic                      scramble_key_valid_i,
  input  logic [scr_pkg::KeyW-1:0]   scramble_key_i,
  input  logic [scr_pkg::NonceW-1:0] scramble_nonce_i,
  output logic                      scramble_req_o,
  output logic [scr_pkg::KeyW-1:0]   key_q_o,
  output logic [scr_pkg::NonceW-1:0] nonce_q_o,
  output logic                      key_valid_o
);

  logic scramble_req_d;
  logic scramble_req_q;
  logic key_valid_d;
  logic key_valid_q;

  ////////////////////////////////////////
  // Key request handshake
  ////////////////////////////////////////

  // Raised by an invalidate, dropped once a key arrives
  assign scramble_req_d = scramble_req_q ? ~scramble_key_valid_i : ram_inval_i;

  // Valid follows the provider while waiting, cleared by invalidate
  assign key_valid_d = scramble_req_q ? scramble_key_valid_i :
                       ram_inval_i    ? 1'b0                 :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scramble_req_q <= 1'b0;
      key_valid_q    <= 1'b1;
    end else begin
      scramble_req_q <= scramble_req_d;
      key_valid_q    <= key_valid_d;
    end
  end

  ////////////////////////////////////////
  // Key and nonce
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q_o   <= scr_pkg::RstKey;
      nonce_q_o <= scr_pkg::RstNonce;
    end else if (scramble_key_valid_i) begin
      key_q_o   <= scramble_key_i;
      nonce_q_o <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = scramble_req_q;
  assign key_valid_o    = key_valid_q;

  // Every request traces back to an invalidate
  req_from_inval_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(scramble_req_o) |-> $past(ram_inval_i));

endmodule

`default_nettype wire

// ==== rtl/scr_pkg.sv ====
// Key and nonce sizes of the scrambling key store.
// The reset values stand in until the key provider delivers a key.
// Both must be at least as wide as a stored memory word.

`default_nettype none

package scr_pkg;

  // Scramble key width
  parameter int unsigned KeyW = 128;

  // Scramble nonce width
  parameter int unsigned NonceW = 64;

  ////////////////////////////////////////
  // Reset defaults
  ////////////////////////////////////////

  // Key in force out of reset
  parameter logic [KeyW-1:0] RstKey = {
    32'h3c5a_91e7,
    32'h8d20_4bf6,
    32'h17e9_c3a2,
    32'h6b04_d85f
  };

  // Nonce in force out of reset
  parameter logic [NonceW-1:0] RstNonce = {
    32'ha7f1_2c68,
    32'h05d9_be43
  };

endpackage

`default_nettype wire

// ==== rtl/scr_ram.sv ====
// Scrambled single-port bank clocked by the gated core clock.
// Scrambling is a plain XOR keystream, so a rekey does not wipe old contents.
// The response has no back-pressure and stays up until the next gated edge.

`timescale 1ns/1ps
`default_nettype none

module scr_ram #(
  parameter  int unsigned NumWords = mem_pkg::DefaultNumWords,
  localparam int unsigned AddrW    = $clog2(NumWords)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clk_en_i,
  input  logic                      key_valid_i,
  input  logic [scr_pkg::KeyW-1:0]   key_i,
  input  logic [scr_pkg::NonceW-1:0] nonce_i,

  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_write_i,
  input  logic [AddrW-1:0]          req_addr_i,
  input  logic [mem_pkg::DataW-1:0] req_wdata_i,
  input  logic [mem_pkg::IntgW-1:0] req_wintg_i,

  output logic                      rsp_valid_o,
  output logic [mem_pkg::DataW-1:0] rsp_rdata_o,
  output logic [mem_pkg::IntgW-1:0] rsp_rintg_o
);

  logic [mem_pkg::WordW-1:0] mem_q [NumWords];
  logic [mem_pkg::WordW-1:0] keystream;
  logic [mem_pkg::WordW-1:0] wword;
  logic [mem_pkg::WordW-1:0] rword_q;
  logic                      req_accept;
  logic                      rsp_valid_q;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // No access while the key is stale or the clock is stopping
  assign req_ready_o = key_valid_i & clk_en_i;
  assign req_accept  = req_valid_i & req_ready_o;

  // Per-address keystream from the current key and nonce
  assign keystream = key_i[mem_pkg::WordW-1:0] ^ nonce_i[mem_pkg::WordW-1:0] ^
                     {{(mem_pkg::WordW - AddrW){1'b0}}, req_addr_i};

  assign wword = {req_wintg_i, req_wdata_i};

  always_ff @(posedge clk_i) begin
    if (req_accept && req_write_i) begin
      mem_q[req_addr_i] <= wword ^ keystream;
    end
  end

  ////////////////////////////////////////
  // Read response
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_accept && !req_write_i) begin
      rword_q <= mem_q[req_addr_i] ^ keystream;
    end
  end

  // One pulse per accepted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_accept & ~req_write_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rword_q[mem_pkg::DataW-1:0];
  assign rsp_rintg_o = rword_q[mem_pkg::WordW-1:mem_pkg::DataW];

  rsp_valid_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(rsp_valid_o));

  // Requester must present a clean payload with valid
  req_payload_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> !$isunknown({req_write_i, req_addr_i, req_wdata_i, req_wintg_i}));

endmodule

`default_nettype wire

// ==== rtl/sleep_ctrl.sv ====
// Main clock gate with its sleep decision.
// Wake inputs must be glitch free while clk_i is low; busy counts one cycle late.
// test_en_i forces the gate open for scan.

`timescale 1ns/1ps
`default_nettype none

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic gated_clk_o,
  output logic clk_en_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic en_latch;
  logic en_at_rise_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the clock running
  assign clk_en_o     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clk_en_o;

  ////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////

  // Transparent while clk_i is low, holds over the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch = clk_en_o | test_en_i;
    end
  end

  assign gated_clk_o = clk_i & en_latch;

  // Enable as the latch closed on it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_at_rise_q <= 1'b0;
    end else begin
      en_at_rise_q <= clk_en_o | test_en_i;
    end
  end

  // No high phase leaks through a closed gate
  gate_closed_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !en_at_rise_q |-> !gated_clk_o);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the shell testbench with Verilator, then search the log for a failure.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ibex_shell -f flist.f -o tb_ibex_shell \
  && ./obj_dir/tb_ibex_shell > sim.log 2>&1 \
  || echo ">>> FAIL" >> sim.log
cat sim.log
if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0
